// File: files.f
+incdir+include
hw/stream_pkg.sv
hw/stats_pkg.sv
hw/stream_framer.sv
hw/packet_checker.sv
hw/lane_event_counter.sv
hw/stats_readout.sv
hw/sanity_top.sv
testbench/tb_sanity_top.sv

// File: hw/lane_event_counter.sv
`timescale 1ns/1ps

module lane_event_counter
	import stream_pkg::*;
#(
	parameter type cnt_t = logic [15:0]
) (
	input logic clk,
	input logic rst_n,
	input logic clr,
	input lane_mask_t inc,
	output cnt_t cnt
);

	// number of lanes flagged this cycle
	cnt_t add;

	always_comb begin
		add = '0;
		for (int i = 0; i < $bits(lane_mask_t); i++) begin
			add = add + cnt_t'(inc[i]);
		end
	end

	// wraps at the width of cnt_t
	// clear wins over a same-cycle increment
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (clr) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + add;
		end
	end

endmodule

// File: hw/packet_checker.sv
`timescale 1ns/1ps
`include "sanity_params.svh"

module packet_checker
	import stream_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input lane_word_t [`LANES-1:0] f_din,
	input lane_mask_t f_sop,
	input eop_t f_eop,
	output lane_mask_t term_err,
	output lane_mask_t serial_err,
	output lane_mask_t dest_err
);

	// stage 1 compare results
	logic [`LANES-1:0][NUM_DEST-1:0] dst_hit;
	logic [`LANES-1:0][NUM_DEST-1:0] ser_hit;
	lane_mask_t term_bad;

	// stage 1 registers
	logic [`LANES-1:0][NUM_DEST-1:0] dst_match_r;
	logic [`LANES-1:0][NUM_DEST-1:0] ser_match_r;
	lane_mask_t sop_r;
	lane_mask_t term_bad_r;

	// expected serial per table entry
	serial_t exp_serial [NUM_DEST];
	serial_t exp_fwd [NUM_DEST];
	logic [NUM_DEST-1:0] ser_inc;

	// pending increment from the packet in stage 1
	// forwarded so back-to-back packets to one destination compare right
	always_comb begin
		for (int k = 0; k < NUM_DEST; k++) begin
			ser_inc[k] = 1'b0;
			for (int i = 0; i < `LANES; i++) begin
				ser_inc[k] = ser_inc[k] | (dst_match_r[i][k] & ser_match_r[i][k]);
			end
			exp_fwd[k] = exp_serial[k] + serial_t'(ser_inc[k]);
		end
	end

	// destination and serial compare on the start word
	always_comb begin
		for (int i = 0; i < `LANES; i++) begin
			for (int k = 0; k < NUM_DEST; k++) begin
				dst_hit[i][k] = f_sop[i] &&
					(f_din[i][`LANE_BITS-1:DEST_LSB] == DEST_TABLE[k]);
				ser_hit[i][k] = (f_din[i][DEST_LSB-1:0] == exp_fwd[k]);
			end
		end
	end

	// terminator compare, bytes 0 up to the eop index must match
	always_comb begin
		logic [7:0] lane_eop;
		logic [7:0] byte_ok;
		logic [7:0] byte_req;
		for (int i = 0; i < `LANES; i++) begin
			lane_eop = f_eop[i*8 +: 8];
			for (int b = 0; b < 8; b++) begin
				byte_ok[b] = (f_din[i][b*8 +: 8] == TERM_WORD[b*8 +: 8]);
				// byte b is checked when the eop index is b or above
				byte_req[b] = ((lane_eop >> b) != 8'd0);
			end
			term_bad[i] = |(byte_req & ~byte_ok);
		end
	end

	// stage 1
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dst_match_r <= '0;
			sop_r <= '0;
			term_bad_r <= '0;
		end else begin
			dst_match_r <= dst_hit;
			sop_r <= f_sop;
			term_bad_r <= term_bad;
		end
	end

	// only meaningful next to a destination match
	always_ff @(posedge clk) begin
		ser_match_r <= ser_hit;
	end

	// stage 2, error masks and serial update
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			term_err <= '0;
			serial_err <= '0;
			dest_err <= '0;
			for (int k = 0; k < NUM_DEST; k++) begin
				exp_serial[k] <= '0;
			end
		end else begin
			term_err <= term_bad_r;
			for (int i = 0; i < `LANES; i++) begin
				// start word with no known destination
				dest_err[i] <= sop_r[i] & ~|dst_match_r[i];
				// known destination, serial out of order
				serial_err[i] <= |(dst_match_r[i] & ~ser_match_r[i]);
			end
			for (int k = 0; k < NUM_DEST; k++) begin
				exp_serial[k] <= exp_fwd[k];
			end
		end
	end

	// one start per cycle from the framer and distinct table entries
	// leave at most one match across all lanes
	a_dst_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(dst_match_r));

endmodule

// File: hw/sanity_top.sv
`timescale 1ns/1ps
`include "sanity_params.svh"

module sanity_top
	import stream_pkg::*;
	import stats_pkg::*;
(
	input logic clk,
	input logic rst_n,
	// stream in
	input lane_word_t [`LANES-1:0] din,
	input lane_mask_t sop,
	input eop_t eop,
	input logic din_valid,
	// host port
	input logic clr,
	input logic rd_req,
	input cnt_sel_t rd_sel,
	output logic rd_ack,
	output evt_cnt_t rd_data
);

	// framed stream, one cycle behind the input
	lane_word_t [`LANES-1:0] f_din;
	lane_mask_t f_sop;
	eop_t f_eop;

	// error masks to the counters
	lane_mask_t frame_err;
	lane_mask_t term_err;
	lane_mask_t serial_err;
	lane_mask_t dest_err;

	stream_framer framer_i (
		.clk(clk),
		.rst_n(rst_n),
		.din(din),
		.sop(sop),
		.eop(eop),
		.din_valid(din_valid),
		.f_din(f_din),
		.f_sop(f_sop),
		.f_eop(f_eop),
		.frame_err(frame_err)
	);

	packet_checker checker_i (
		.clk(clk),
		.rst_n(rst_n),
		.f_din(f_din),
		.f_sop(f_sop),
		.f_eop(f_eop),
		.term_err(term_err),
		.serial_err(serial_err),
		.dest_err(dest_err)
	);

	stats_readout stats_i (
		.clk(clk),
		.rst_n(rst_n),
		.clr(clr),
		.frame_err(frame_err),
		.term_err(term_err),
		.serial_err(serial_err),
		.dest_err(dest_err),
		.rd_req(rd_req),
		.rd_sel(rd_sel),
		.rd_ack(rd_ack),
		.rd_data(rd_data)
	);

endmodule

// File: hw/stats_pkg.sv
`include "sanity_params.svh"

package stats_pkg;

	// counter picked by the host on a read
	typedef enum logic [1:0] {
		sel_framing = 2'd0,
		sel_term = 2'd1,
		sel_serial = 2'd2,
		sel_dest = 2'd3
	} cnt_sel_t;

	// terminator, serial and destination counts
	typedef logic [`EVT_CNT_BITS-1:0] evt_cnt_t;

	// framing count
	typedef logic [`FRM_CNT_BITS-1:0] frm_cnt_t;

endpackage

// File: hw/stats_readout.sv
`timescale 1ns/1ps

module stats_readout
	import stats_pkg::*;
	import stream_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic clr,
	input lane_mask_t frame_err,
	input lane_mask_t term_err,
	input lane_mask_t serial_err,
	input lane_mask_t dest_err,
	input logic rd_req,
	input cnt_sel_t rd_sel,
	output logic rd_ack,
	output evt_cnt_t rd_data
);

	typedef enum logic {
		st_idle,
		st_ack
	} rd_state_t;

	rd_state_t state;

	frm_cnt_t frm_cnt;
	evt_cnt_t term_cnt;
	evt_cnt_t serial_cnt;
	evt_cnt_t dest_cnt;
	evt_cnt_t sel_cnt;

	lane_event_counter #(.cnt_t(frm_cnt_t)) frm_cnt_i (
		.clk(clk), .rst_n(rst_n), .clr(clr), .inc(frame_err), .cnt(frm_cnt)
	);

	lane_event_counter #(.cnt_t(evt_cnt_t)) term_cnt_i (
		.clk(clk), .rst_n(rst_n), .clr(clr), .inc(term_err), .cnt(term_cnt)
	);

	lane_event_counter #(.cnt_t(evt_cnt_t)) serial_cnt_i (
		.clk(clk), .rst_n(rst_n), .clr(clr), .inc(serial_err), .cnt(serial_cnt)
	);

	lane_event_counter #(.cnt_t(evt_cnt_t)) dest_cnt_i (
		.clk(clk), .rst_n(rst_n), .clr(clr), .inc(dest_err), .cnt(dest_cnt)
	);

	// framing count is zero-extended
	always_comb begin
		case (rd_sel)
			sel_framing: sel_cnt = evt_cnt_t'(frm_cnt);
			sel_term: sel_cnt = term_cnt;
			sel_serial: sel_cnt = serial_cnt;
			default: sel_cnt = dest_cnt;
		endcase
	end

	// four-phase handshake, ack follows req by one cycle both ways
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: if (rd_req) state <= st_ack;
				default: if (!rd_req) state <= st_idle;
			endcase
		end
	end

	// captured once per read, held while ack is up
	always_ff @(posedge clk) begin
		if (state == st_idle && rd_req)
			rd_data <= sel_cnt;
	end

	assign rd_ack = (state == st_ack);

	// host keeps the select steady until the read is acknowledged
	a_sel_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_req && !rd_ack) |=> $stable(rd_sel));

endmodule

// File: hw/stream_framer.sv
`timescale 1ns/1ps
`include "sanity_params.svh"

module stream_framer
	import stream_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input lane_word_t [`LANES-1:0] din,
	input lane_mask_t sop,
	input eop_t eop,
	input logic din_valid,
	output lane_word_t [`LANES-1:0] f_din,
	output lane_mask_t f_sop,
	output eop_t f_eop,
	output lane_mask_t frame_err
);

	// sop and eop qualified by valid
	lane_mask_t sop_v;
	lane_mask_t eop_v;

	// packet state
	logic pkt_open;
	logic pkt_open_nx;
	lane_mask_t frame_err_nx;

	always_comb begin
		sop_v = din_valid ? sop : '0;
		for (int i = 0; i < `LANES; i++) begin
			eop_v[i] = din_valid && (eop[i*8 +: 8] != 8'd0);
		end
	end

	// walk lane 0 first, the open flag carries to the next lane
	// sop is taken before eop inside one lane
	always_comb begin
		logic open_v;
		open_v = pkt_open;
		frame_err_nx = '0;
		for (int i = 0; i < `LANES; i++) begin
			if (sop_v[i]) begin
				// start inside an open packet
				if (open_v)
					frame_err_nx[i] = 1'b1;
				open_v = 1'b1;
			end
			if (eop_v[i]) begin
				// end with nothing open
				if (!open_v)
					frame_err_nx[i] = 1'b1;
				open_v = 1'b0;
			end
		end
		pkt_open_nx = open_v;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pkt_open <= 1'b0;
			f_sop <= '0;
			f_eop <= '0;
			frame_err <= '0;
		end else begin
			pkt_open <= pkt_open_nx;
			f_sop <= sop_v;
			f_eop <= din_valid ? eop : '0;
			frame_err <= frame_err_nx;
		end
	end

	// payload, zeroed on idle cycles
	always_ff @(posedge clk) begin
		f_din <= din_valid ? din : '0;
	end

	// every packet spans two words or more
	a_one_sop: assert property (@(posedge clk) disable iff (!rst_n)
		din_valid |-> $onehot0(sop));

endmodule

// File: hw/stream_pkg.sv
`include "sanity_params.svh"

package stream_pkg;

	// one lane of payload
	typedef logic [`LANE_BITS-1:0] lane_word_t;

	// one bit per lane, for sop and the error vectors
	typedef logic [`LANES-1:0] lane_mask_t;

	// 8 bits per lane, one-hot index of the last valid byte
	// an all-zero byte means the lane does not end a packet
	typedef logic [`LANES*8-1:0] eop_t;

	// packet serial number carried in the start word
	typedef logic [15:0] serial_t;

	// destination address carried in the start word
	typedef logic [47:0] mac_addr_t;

	// start word layout: destination above this bit, serial below
	localparam int DEST_LSB = 16;

	// known destinations
	localparam int NUM_DEST = 4;

	localparam mac_addr_t DEST_TABLE [NUM_DEST] = '{
		48'h00215a_bdde43,
		48'h123456_ff1234,
		48'h0007ed_ff0000,
		48'h0007ed_ff1234
	};

	// fixed string "caboose." in the last word of every packet
	// byte 0 holds 'c' and sits in bits 7:0
	// so the literal reads back to front
	localparam lane_word_t TERM_WORD = ".esoobac";

endpackage

// File: include/sanity_params.svh
`ifndef SANITY_PARAMS_SVH
`define SANITY_PARAMS_SVH

// number of lanes carried per cycle
`define LANES 2

// bits per lane word
`define LANE_BITS 64

// width of the terminator, serial and destination counts
`define EVT_CNT_BITS 32

// framing count is narrower, it is zero-extended on readout
`define FRM_CNT_BITS 16

`endif

// File: run_sim.sh
#!/bin/sh
# build and run the sanity monitor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sanity_top \
	-f files.f \
	-o Vtb_sanity_top

# the simulator may exit non-zero on $fatal, the log decides the result
./obj_dir/Vtb_sanity_top 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "run_sim: FAIL"
	exit 1
fi

if ! grep -q "Simulation completed successfully" sim.log; then
	echo "run_sim: FAIL, no result line in sim.log"
	exit 1
fi

echo "run_sim: PASS"

// File: testbench/tb_sanity_top.sv
`timescale 1ns/1ps
`include "sanity_params.svh"

module tb_sanity_top
	import stream_pkg::*;
	import stats_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 3;
	// rough length of the run, used by the watchdog
	localparam int NUM_PKTS = 24;
	localparam int PKT_CYCLES = 3;
	localparam int NUM_READS = 28;
	localparam int READ_CYCLES = 4;
	localparam int NUM_TESTS = 7;
	localparam int SETTLE_CYCLES = 8;
	localparam int TEST_CYCLES = RESET_CYCLES + NUM_PKTS * PKT_CYCLES
		+ NUM_READS * READ_CYCLES + NUM_TESTS * SETTLE_CYCLES;
	localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD + 2000;
	// cycles allowed for each edge of rd_ack
	localparam int ACK_TIMEOUT = 8;

	logic clk;
	logic rst_n;
	lane_word_t [`LANES-1:0] din;
	lane_mask_t sop;
	eop_t eop;
	logic din_valid;
	logic clr;
	logic rd_req;
	cnt_sel_t rd_sel;
	logic rd_ack;
	evt_cnt_t rd_data;

	integer seed;
	// next serial the monitor should accept, per table entry
	serial_t exp_ser [NUM_DEST];
	// rd_ack latency seen on the last read
	int ack_rise_cycles;
	int ack_fall_cycles;

	sanity_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.din(din),
		.sop(sop),
		.eop(eop),
		.din_valid(din_valid),
		.clr(clr),
		.rd_req(rd_req),
		.rd_sel(rd_sel),
		.rd_ack(rd_ack),
		.rd_data(rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_run();
		$display("Simulation failed");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic report_failure(input string msg);
		$display("%s (at %0t)", msg, $time);
		stop_run();
	endtask

	task automatic evt_compare(input string what, input evt_cnt_t got, input evt_cnt_t want);
		if (got !== want) begin
			$display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, want);
			stop_run();
		end
	endtask

	task automatic frm_compare(input string what, input frm_cnt_t got, input frm_cnt_t want);
		if (got !== want) begin
			$display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, want);
			stop_run();
		end
	endtask

	// table index of an address, -1 when unknown
	function automatic int dest_index(input mac_addr_t d);
		for (int k = 0; k < NUM_DEST; k++) begin
			if (d == DEST_TABLE[k])
				return k;
		end
		return -1;
	endfunction

	// serial advances only on a known destination with the expected serial
	task automatic note_start(input mac_addr_t d, input serial_t s);
		int k;
		k = dest_index(d);
		if (k >= 0 && s == exp_ser[k])
			exp_ser[k] = exp_ser[k] + 16'd1;
	endtask

	// one valid stream cycle, sampled on the next rising edge
	task automatic drive_cycle(input lane_word_t [`LANES-1:0] w, input lane_mask_t s,
		input eop_t e);
		@(posedge clk);
		#2;
		din = w;
		sop = s;
		eop = e;
		din_valid = 1'b1;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
			din = '0;
			sop = '0;
			eop = '0;
			din_valid = 1'b0;
		end
	endtask

	task automatic clear_counters();
		@(posedge clk);
		#2;
		clr = 1'b1;
		@(posedge clk);
		#2;
		clr = 1'b0;
	endtask

	// start word, random middle words, last word with a one-hot eop
	task automatic send_packet(input mac_addr_t d, input serial_t s, input int n_words,
		input int first_lane, input lane_word_t last_word, input int eop_idx);
		lane_word_t [`LANES-1:0] word_m;
		lane_mask_t sop_m;
		eop_t eop_m;
		int lane;
		lane = first_lane;
		word_m = '0;
		sop_m = '0;
		eop_m = '0;
		note_start(d, s);
		for (int i = 0; i < n_words; i++) begin
			if (i == 0) begin
				word_m[lane] = {d, s};
				sop_m[lane] = 1'b1;
			end else if (i == n_words - 1) begin
				word_m[lane] = last_word;
				eop_m[lane*8 +: 8] = 8'd1 << eop_idx;
			end else begin
				word_m[lane] = {$random(seed), $random(seed)};
			end
			lane++;
			// lanes full or packet done, put the cycle out
			if (lane == `LANES || i == n_words - 1) begin
				drive_cycle(word_m, sop_m, eop_m);
				lane = 0;
				word_m = '0;
				sop_m = '0;
				eop_m = '0;
			end
		end
	endtask

	task automatic send_good_packet(input int k, input int n_words, input int first_lane,
		input int eop_idx);
		send_packet(DEST_TABLE[k], exp_ser[k], n_words, first_lane, TERM_WORD, eop_idx);
	endtask

	// four-phase read, waits for each edge of rd_ack
	task automatic read_counter(input cnt_sel_t sel, output evt_cnt_t val);
		int n;
		@(posedge clk);
		#2;
		rd_sel = sel;
		rd_req = 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			#2;
			n++;
		end while (!rd_ack && n < ACK_TIMEOUT);
		if (!rd_ack)
			report_failure("read handshake: rd_ack never rose after rd_req");
		ack_rise_cycles = n;
		val = rd_data;
		rd_req = 1'b0;
		n = 0;
		do begin
			@(posedge clk);
			#2;
			n++;
		end while (rd_ack && n < ACK_TIMEOUT);
		if (rd_ack)
			report_failure("read handshake: rd_ack stayed high after rd_req dropped");
		ack_fall_cycles = n;
	endtask

	task automatic expect_counts(input int frm, input int term, input int ser, input int dst);
		evt_cnt_t v;
		read_counter(sel_framing, v);
		frm_compare("framing count", frm_cnt_t'(v), frm_cnt_t'(frm));
		// upper bits of the framing read must be zero
		if ((v >> `FRM_CNT_BITS) != '0)
			report_failure("framing read: upper bits of rd_data are not zero");
		read_counter(sel_term, v);
		evt_compare("terminator count", v, evt_cnt_t'(term));
		read_counter(sel_serial, v);
		evt_compare("serial count", v, evt_cnt_t'(ser));
		read_counter(sel_dest, v);
		evt_compare("destination count", v, evt_cnt_t'(dst));
	endtask

	// ten clean packets, sop in both lanes, some back to back to one destination
	task automatic good_packet_stream();
		int dst_seq [10] = '{0, 1, 1, 2, 3, 0, 0, 2, 1, 3};
		clear_counters();
		for (int i = 0; i < 10; i++) begin
			send_good_packet(dst_seq[i], 2 + (i % 4), i % 2, 7 - (i % 8));
		end
		idle_cycles(6);
		expect_counts(0, 0, 0, 0);
	endtask

	// wrong serial leaves the expected one in place
	task automatic serial_tracking();
		serial_t e;
		clear_counters();
		e = exp_ser[2];
		send_packet(DEST_TABLE[2], e + 16'd5, 3, 0, TERM_WORD, 7);
		send_packet(DEST_TABLE[2], e, 2, 1, TERM_WORD, 7);
		send_good_packet(2, 4, 0, 7);
		idle_cycles(6);
		expect_counts(0, 0, 1, 0);
	endtask

	task automatic unknown_destination();
		mac_addr_t stranger;
		stranger = 48'h0a0b0c_0d0e0f;
		clear_counters();
		send_packet(stranger, 16'd0, 3, 1, TERM_WORD, 7);
		send_packet(stranger, 16'd1, 2, 0, TERM_WORD, 7);
		idle_cycles(6);
		expect_counts(0, 0, 0, 2);
	endtask

	// only bytes 0 up to the eop index are compared
	task automatic terminator_bytes();
		lane_word_t bad_low;
		lane_word_t bad_at;
		lane_word_t bad_high;
		bad_low = TERM_WORD ^ (64'hff << 24);
		bad_at = TERM_WORD ^ (64'hff << 32);
		bad_high = TERM_WORD ^ (64'hff << 40);
		clear_counters();
		// byte 3 wrong, eop at 7
		send_packet(DEST_TABLE[1], exp_ser[1], 3, 0, bad_low, 7);
		// byte 4 wrong, eop at 4
		send_packet(DEST_TABLE[0], exp_ser[0], 2, 0, bad_at, 4);
		// byte 5 wrong, eop at 3, not counted
		send_packet(DEST_TABLE[3], exp_ser[3], 2, 1, bad_high, 3);
		idle_cycles(6);
		expect_counts(0, 2, 0, 0);
	endtask

	task automatic framing_violations();
		lane_word_t [`LANES-1:0] w;
		clear_counters();
		// stray eop on lane 0
		w = '0;
		w[0] = TERM_WORD;
		drive_cycle(w, 2'b00, {8'h00, 8'h80});
		// open a packet to entry 0
		w = '0;
		w[0] = {DEST_TABLE[0], exp_ser[0]};
		note_start(DEST_TABLE[0], exp_ser[0]);
		drive_cycle(w, 2'b01, '0);
		// second start while still open
		w = '0;
		w[1] = {DEST_TABLE[1], exp_ser[1]};
		note_start(DEST_TABLE[1], exp_ser[1]);
		drive_cycle(w, 2'b10, '0);
		// lane 0 closes the packet, lane 1 ends nothing
		w[0] = TERM_WORD;
		w[1] = TERM_WORD;
		drive_cycle(w, 2'b00, {8'h80, 8'h80});
		idle_cycles(6);
		expect_counts(3, 0, 0, 0);
	endtask

	task automatic readout_and_clear();
		lane_word_t [`LANES-1:0] w;
		if (rd_ack !== 1'b0)
			report_failure("readout: rd_ack high with no read pending");
		clear_counters();
		// unknown destination with byte 0 of the terminator wrong
		send_packet(48'h0a0b0c_0d0e10, 16'd9, 2, 0, TERM_WORD ^ 64'h1, 7);
		send_packet(DEST_TABLE[0], exp_ser[0] + 16'd3, 2, 1, TERM_WORD, 7);
		w = '0;
		w[1] = TERM_WORD;
		drive_cycle(w, 2'b00, {8'h80, 8'h00});
		idle_cycles(6);
		expect_counts(1, 1, 1, 1);
		if (ack_rise_cycles != 1)
			report_failure("readout: rd_ack did not rise one cycle after rd_req");
		if (ack_fall_cycles != 1)
			report_failure("readout: rd_ack did not fall one cycle after rd_req dropped");
		clear_counters();
		expect_counts(0, 0, 0, 0);
	endtask

	initial begin
		seed = 32'h476c;
		rst_n = 1'b0;
		din = '0;
		sop = '0;
		eop = '0;
		din_valid = 1'b0;
		clr = 1'b0;
		rd_req = 1'b0;
		rd_sel = sel_framing;
		ack_rise_cycles = 0;
		ack_fall_cycles = 0;
		for (int k = 0; k < NUM_DEST; k++) begin
			exp_ser[k] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;

		good_packet_stream();
		serial_tracking();
		unknown_destination();
		terminator_bytes();
		framing_violations();
		readout_and_clear();

		$display("Simulation completed successfully");
		$finish;
	end

	// ends a run that stalls
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: tests still running after %0d ns", WATCHDOG_NS);
		stop_run();
	end

endmodule
